// File: hdl/mmio_pkg.sv
package mmio_pkg;

    // cpu and data memory op codes, encoding kept from the cpu side
    typedef enum logic [1:0] {
        rw_read_instr = 2'b00, // instruction read
        rw_write      = 2'b01, // write to target
        rw_read       = 2'b10, // data read
        rw_idle       = 2'b11  // no request
    } rw_op_e;

    // decoded target of a request
    typedef enum logic [2:0] {
        region_fetch = 3'd0, // instruction fetch from memory
        region_reg   = 3'd1, // external register, read only
        region_mem   = 3'd2, // data memory, read or write
        region_tft   = 3'd3, // spi tft display, write only
        region_none  = 3'd4  // unmapped address or illegal op
    } region_e;

    // address map upper bounds, each inclusive
    localparam logic [31:0] fetch_top = 32'd1024; // last fetch address
    localparam logic [31:0] reg_top   = 32'd1056; // last external register address
    localparam logic [31:0] mem_top   = 32'd1792; // last data memory address
    localparam logic [31:0] tft_top   = 32'd2047; // last display address

    // top byte of every memory side address
    localparam logic [7:0] mem_prefix = 8'h33;

    // external register index width
    localparam int reg_addr_w = 5;

endpackage

// File: hdl/mmio_if.sv
`timescale 1ns/1ps

// decoded request from stage 1 to stage 2
interface mmio_req_if;
    import mmio_pkg::*;

    logic        valid; // entry holds a live request
    region_e     region; // decoded target
    rw_op_e      op; // cpu op code as sampled
    logic [31:0] addr; // cpu address as sampled
    logic [31:0] wdata; // cpu write data as sampled
    logic        stall; // selected target still processing

    // entry must stay put while stall is high
    modport decode (output valid, region, op, addr, wdata, input stall);
    modport route  (input valid, region, op, addr, wdata, output stall);

endinterface

// completed response from stage 2 to stage 3
interface mmio_rsp_if;
    import mmio_pkg::*;

    logic        valid; // one cycle per finished request
    region_e     region; // region_none when no data comes back
    logic [31:0] rdata; // read data from the target

    modport route (output valid, region, rdata);
    modport ret   (input valid, region, rdata);

endinterface

// File: hdl/mmio_addr_decode.sv
`timescale 1ns/1ps

module mmio_addr_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [31:0]      cpu_addr,
    input  mmio_pkg::rw_op_e cpu_rwi,
    input  logic [31:0]      cpu_wdata,
    output logic             busy,
    mmio_req_if.decode       req
);
    import mmio_pkg::*;

    logic    nxt_valid; // cpu asks for something
    region_e nxt_region; // region the request maps to

    // address map plus the per region op rules
    always_comb begin
        nxt_valid  = (cpu_rwi != rw_idle);
        nxt_region = region_none; // default is unmapped
        if (cpu_rwi != rw_idle) begin
            if (cpu_addr <= fetch_top) begin
                nxt_region = region_fetch; // any live op here is a fetch
            end else if (cpu_addr <= reg_top) begin
                if (cpu_rwi == rw_read) begin
                    nxt_region = region_reg; // register is read only
                end
            end else if (cpu_addr <= mem_top) begin
                if (cpu_rwi == rw_read || cpu_rwi == rw_write) begin
                    nxt_region = region_mem;
                end
            end else if (cpu_addr <= tft_top) begin
                if (cpu_rwi == rw_write) begin
                    nxt_region = region_tft; // display takes writes only
                end
            end
        end
    end

    // control part of the entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req.valid  <= 1'b0;
            req.region <= region_none;
            req.op     <= rw_idle;
        end else if (!req.stall) begin // hold while the target works
            req.valid  <= nxt_valid;
            req.region <= nxt_region;
            req.op     <= cpu_rwi;
        end
    end

    // payload part, only looked at while valid
    always_ff @(posedge clk) begin
        if (!req.stall) begin
            req.addr  <= cpu_addr;
            req.wdata <= cpu_wdata;
        end
    end

    assign busy = req.stall; // cpu keeps its request while high

endmodule

// File: hdl/mmio_target_route.sv
`timescale 1ns/1ps

module mmio_target_route (
    mmio_req_if.route                      req,
    mmio_rsp_if.route                      rsp,
    output logic                           reg_ri,
    output logic [mmio_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [31:0]                    reg_rdata,
    input  logic                           reg_ack,
    output logic                           tft_wi,
    output logic [31:0]                    tft_addr,
    output logic [31:0]                    tft_wdata,
    input  logic                           tft_ack,
    output mmio_pkg::rw_op_e               mem_rwi,
    output logic [31:0]                    mem_addr,
    output logic [31:0]                    mem_wdata,
    input  logic [31:0]                    mem_rdata,
    input  logic                           mem_busy
);
    import mmio_pkg::*;

    logic        wait_sel; // wait level of the driven target
    logic [31:0] rdata_sel; // read data of the driven target
    logic        no_data; // request returns nothing to the cpu

    always_comb begin
        reg_ri    = 1'b0; // register idle
        reg_addr  = '0;
        tft_wi    = 1'b0; // display idle
        tft_addr  = '0;
        tft_wdata = '0;
        mem_rwi   = rw_idle; // memory idle
        mem_addr  = '0;
        mem_wdata = '0;
        wait_sel  = 1'b0; // unmapped never waits
        rdata_sel = '0; // unmapped reads zero
        no_data   = 1'b1;
        if (req.valid) begin
            case (req.region)
                region_fetch: begin
                    mem_rwi   = rw_read; // fetch is a plain memory read
                    mem_addr  = {mem_prefix, req.addr[23:0]};
                    wait_sel  = mem_busy;
                    rdata_sel = mem_rdata;
                    no_data   = 1'b0;
                end
                region_reg: begin
                    reg_ri    = 1'b1;
                    reg_addr  = req.addr[reg_addr_w-1:0]; // low bits index the register
                    wait_sel  = reg_ack;
                    rdata_sel = reg_rdata;
                    no_data   = 1'b0;
                end
                region_mem: begin
                    mem_rwi  = req.op; // rw_read or rw_write after decode
                    mem_addr = {mem_prefix, req.addr[23:0]};
                    wait_sel = mem_busy;
                    if (req.op == rw_write) begin
                        mem_wdata = req.wdata;
                    end else begin
                        rdata_sel = mem_rdata;
                        no_data   = 1'b0;
                    end
                end
                region_tft: begin
                    tft_wi    = 1'b1;
                    tft_addr  = req.addr; // display gets the full address
                    tft_wdata = req.wdata;
                    wait_sel  = tft_ack;
                end
                default: begin
                    wait_sel = 1'b0; // unmapped, drive nothing
                end
            endcase
        end
    end

    assign req.stall = req.valid & wait_sel; // back-pressure into decode

    // response leaves in the cycle the target stops waiting
    assign rsp.valid  = req.valid & ~wait_sel;
    assign rsp.region = no_data ? region_none : req.region; // writes carry no data
    assign rsp.rdata  = rdata_sel;

endmodule

// File: hdl/mmio_return_stage.sv
`timescale 1ns/1ps

module mmio_return_stage (
    input  logic        clk,
    input  logic        arst_n,
    mmio_rsp_if.ret     rsp,
    output logic [31:0] cpu_rdata,
    output logic [31:0] instr,
    output logic        done
);
    import mmio_pkg::*;

    logic is_instr; // response is a fetched instruction
    logic is_data; // response is register or memory read data

    assign is_instr = rsp.valid && (rsp.region == region_fetch);
    assign is_data  = rsp.valid && (rsp.region == region_reg || rsp.region == region_mem);

    // done is a single cycle pulse per response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= rsp.valid;
        end
    end

    // each output keeps its value until the next response of its kind
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr     <= '0;
            cpu_rdata <= '0;
        end else begin
            if (is_instr) begin
                instr <= rsp.rdata; // next instruction for fetch
            end
            if (is_data) begin
                cpu_rdata <= rsp.rdata; // load data for the cpu
            end
        end
    end

endmodule

// File: hdl/mmio_bridge.sv
`timescale 1ns/1ps

module mmio_bridge (
    input  logic                            clk,
    input  logic                            arst_n,
    // cpu side
    input  logic [31:0]                     cpu_addr,
    input  mmio_pkg::rw_op_e                cpu_rwi,
    input  logic [31:0]                     cpu_wdata,
    output logic                            busy,
    output logic                            done,
    output logic [31:0]                     cpu_rdata,
    output logic [31:0]                     instr,
    // external register
    output logic                            reg_ri,
    output logic [mmio_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [31:0]                     reg_rdata,
    input  logic                            reg_ack, // high while still processing
    // spi tft display
    output logic                            tft_wi,
    output logic [31:0]                     tft_addr,
    output logic [31:0]                     tft_wdata,
    input  logic                            tft_ack, // high while still processing
    // instruction and data memory
    output mmio_pkg::rw_op_e                mem_rwi,
    output logic [31:0]                     mem_addr,
    output logic [31:0]                     mem_wdata,
    input  logic [31:0]                     mem_rdata,
    input  logic                            mem_busy
);

    mmio_req_if u_req (); // decode to route
    mmio_rsp_if u_rsp (); // route to return

    mmio_addr_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_addr  (cpu_addr),
        .cpu_rwi   (cpu_rwi),
        .cpu_wdata (cpu_wdata),
        .busy      (busy),
        .req       (u_req.decode)
    );

    mmio_target_route u_route (
        .req       (u_req.route),
        .rsp       (u_rsp.route),
        .reg_ri    (reg_ri),
        .reg_addr  (reg_addr),
        .reg_rdata (reg_rdata),
        .reg_ack   (reg_ack),
        .tft_wi    (tft_wi),
        .tft_addr  (tft_addr),
        .tft_wdata (tft_wdata),
        .tft_ack   (tft_ack),
        .mem_rwi   (mem_rwi),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy)
    );

    mmio_return_stage u_return (
        .clk       (clk),
        .arst_n    (arst_n),
        .rsp       (u_rsp.ret),
        .cpu_rdata (cpu_rdata),
        .instr     (instr),
        .done      (done)
    );

endmodule

// File: testbench/mmio_checker.sv
`timescale 1ns/1ps

module mmio_checker (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [31:0]                     cpu_addr,
    input  mmio_pkg::rw_op_e                cpu_rwi,
    input  logic [31:0]                     cpu_wdata,
    input  logic                            busy,
    input  logic                            done,
    input  logic [31:0]                     cpu_rdata,
    input  logic [31:0]                     instr,
    input  logic                            reg_ri,
    input  logic [mmio_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [31:0]                     reg_rdata,
    input  logic                            reg_ack,
    input  logic                            tft_wi,
    input  logic [31:0]                     tft_addr,
    input  logic [31:0]                     tft_wdata,
    input  logic                            tft_ack,
    input  mmio_pkg::rw_op_e                mem_rwi,
    input  logic [31:0]                     mem_addr,
    input  logic [31:0]                     mem_wdata,
    input  logic [31:0]                     mem_rdata,
    input  logic                            mem_busy,
    output int                              error_count,
    output int                              resp_count
);
    import mmio_pkg::*;

    localparam logic [1:0] st_idle   = 2'd0; // nothing in flight
    localparam logic [1:0] st_route  = 2'd1; // request drives its target
    localparam logic [1:0] st_return = 2'd2; // done expected now

    logic [1:0]  st;
    region_e     cap_region; // predicted region of the request in flight
    rw_op_e      cap_op;
    logic [31:0] cap_addr;
    logic [31:0] cap_wdata;
    logic [31:0] exp_data; // model data taken when the wait ends
    logic [31:0] exp_instr; // last fetched instruction
    logic [31:0] exp_rdata; // last register or memory read

    initial begin
        error_count = 0;
        resp_count  = 0;
        st          = st_idle;
    end

    // region straight from the address map and the op rules
    function automatic region_e region_of(input logic [31:0] a, input rw_op_e op);
        if (op == rw_idle) return region_none;
        if (a <= fetch_top) return region_fetch; // any live op fetches
        if (a <= reg_top) return (op == rw_read) ? region_reg : region_none;
        if (a <= mem_top) return (op == rw_read || op == rw_write) ? region_mem : region_none;
        if (a <= tft_top) return (op == rw_write) ? region_tft : region_none;
        return region_none;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // strobes of every target, address and data of the selected one
    task automatic check_targets(input region_e rg);
        rw_op_e exp_op;
        exp_op = rw_idle;
        if (rg == region_fetch) exp_op = rw_read; // fetch reads memory
        if (rg == region_mem) exp_op = cap_op;
        check_val("reg_ri", rg == region_reg, reg_ri);
        check_val("tft_wi", rg == region_tft, tft_wi);
        check_val("mem_rwi", exp_op, mem_rwi);
        if (rg == region_fetch || rg == region_mem)
            check_val("mem_addr", {mem_prefix, cap_addr[23:0]}, mem_addr);
        if (rg == region_mem && cap_op == rw_write) check_val("mem_wdata", cap_wdata, mem_wdata);
        if (rg == region_reg) check_val("reg_addr", cap_addr[reg_addr_w-1:0], reg_addr);
        if (rg == region_tft) begin
            check_val("tft_addr", cap_addr, tft_addr);
            check_val("tft_wdata", cap_wdata, tft_wdata);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n !== 1'b1) begin
            st        = st_idle;
            exp_instr = '0;
            exp_rdata = '0;
            check_val("reg_ri", 1'b0, reg_ri); // reset values
            check_val("tft_wi", 1'b0, tft_wi);
            check_val("done", 1'b0, done);
            check_val("busy", 1'b0, busy);
            check_val("mem_rwi", rw_idle, mem_rwi);
            check_val("reg_addr", '0, reg_addr);
            check_val("tft_addr", '0, tft_addr);
            check_val("tft_wdata", '0, tft_wdata);
            check_val("mem_addr", '0, mem_addr);
            check_val("mem_wdata", '0, mem_wdata);
        end else begin
            if (st == st_route) begin
                check_targets(cap_region);
                check_val("done", 1'b0, done);
                if ((cap_region == region_reg && reg_ack)
                    || (cap_region == region_tft && tft_ack)
                    || ((cap_region == region_fetch || cap_region == region_mem) && mem_busy)) begin
                    check_val("busy", 1'b1, busy); // target still working
                end else begin
                    check_val("busy", 1'b0, busy);
                    exp_data = (cap_region == region_reg) ? reg_rdata : mem_rdata;
                    st       = st_return;
                end
            end else if (st == st_return) begin
                check_targets(region_none);
                check_val("done", 1'b1, done);
                if (cap_region == region_fetch) exp_instr = exp_data;
                if (cap_region == region_reg || (cap_region == region_mem && cap_op == rw_read))
                    exp_rdata = exp_data;
                resp_count++;
                st = st_idle;
            end else begin
                check_targets(region_none); // nothing may be strobed
                check_val("done", 1'b0, done);
                check_val("busy", 1'b0, busy);
            end
            check_val("instr", exp_instr, instr); // held between fetches
            check_val("cpu_rdata", exp_rdata, cpu_rdata); // held between reads
            if (st == st_idle && cpu_rwi != rw_idle && !busy) begin
                cap_addr   = cpu_addr; // sampled at the coming edge
                cap_op     = cpu_rwi;
                cap_wdata  = cpu_wdata;
                cap_region = region_of(cpu_addr, cpu_rwi);
                st         = st_route;
            end
        end
    end

endmodule

// File: testbench/tb_mmio_bridge.sv
`timescale 1ns/1ps

module tb_mmio_bridge;
    import mmio_pkg::*;

    localparam int n_req     = 18; // lines in the trace
    localparam int cycle_max = n_req * 8 + 8 + 20; // watchdog limit

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] cpu_addr;
    rw_op_e      cpu_rwi;
    logic [31:0] cpu_wdata;
    logic        busy;
    logic        done;
    logic [31:0] cpu_rdata;
    logic [31:0] instr;
    logic        reg_ri;
    logic [reg_addr_w-1:0] reg_addr;
    logic [31:0] reg_rdata;
    logic        reg_ack;
    logic        tft_wi;
    logic [31:0] tft_addr;
    logic [31:0] tft_wdata;
    logic        tft_ack;
    rw_op_e      mem_rwi;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_busy;
    logic [31:0] trace_mem [0:n_req*4-1]; // four words per request
    logic [15:0] lfsr_state;
    int          cycle_cnt = 0;
    int          tb_errors;
    int          error_count;
    int          resp_count;

    always #5 clk = ~clk; // 10 ns period

    mmio_bridge u_dut (.*);

    mmio_checker u_chk (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // galois, taps 16 14 13 11
    endfunction

    // a model outside its own address window reports still processing
    task automatic set_wait_levels(input logic level, input logic own_reg,
                                   input logic own_tft, input logic own_mem);
        reg_ack  <= own_reg ? level : 1'b1;
        tft_ack  <= own_tft ? level : 1'b1;
        mem_busy <= own_mem ? level : 1'b1;
    endtask

    // one request from the trace, then wait for done
    task automatic run_request(input int idx);
        logic [1:0]  wait_len;
        int          wait_cnt;
        logic        accepted;
        logic        got_done;
        logic [31:0] addr;
        logic        own_reg; // address lies in the register window
        logic        own_tft; // address lies in the display window
        logic        own_mem; // address lies in the fetch or data window
        addr    = trace_mem[idx*4];
        own_reg = (addr > fetch_top) && (addr <= reg_top);
        own_tft = (addr > mem_top) && (addr <= tft_top);
        own_mem = (addr <= mem_top) && !own_reg;
        @(posedge clk);
        cpu_addr   <= addr;
        cpu_rwi    <= rw_op_e'(trace_mem[idx*4+1][1:0]);
        cpu_wdata  <= trace_mem[idx*4+2];
        // only the owning model answers with the trace data
        reg_rdata  <= own_reg ? trace_mem[idx*4+3] : ~trace_mem[idx*4+3];
        mem_rdata  <= own_mem ? trace_mem[idx*4+3] : ~trace_mem[idx*4+3];
        wait_len[0] = lfsr_state[0];
        lfsr_state  = lfsr_next(lfsr_state);
        wait_len[1] = lfsr_state[0];
        lfsr_state  = lfsr_next(lfsr_state);
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !busy; // taken at the next edge
            @(posedge clk);
        end
        cpu_rwi  <= rw_idle; // one accepted cycle only
        wait_cnt = wait_len;
        set_wait_levels(wait_cnt != 0, own_reg, own_tft, own_mem);
        got_done = 1'b0;
        while (!got_done) begin
            @(negedge clk);
            got_done = done;
            if (!got_done) begin
                @(posedge clk);
                if (wait_cnt != 0) wait_cnt--;
                set_wait_levels(wait_cnt != 0, own_reg, own_tft, own_mem);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_max) begin
            $display("run timed out after %0d cycles, done never came", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        arst_n     = 1'b0;
        cpu_addr   = '0;
        cpu_rwi    = rw_idle;
        cpu_wdata  = '0;
        reg_rdata  = '0;
        reg_ack    = 1'b0;
        tft_ack    = 1'b0;
        mem_rdata  = '0;
        mem_busy   = 1'b0;
        lfsr_state = 16'd17858;
        tb_errors  = 0;
        $readmemh("testbench/mmio_trace.txt", trace_mem);
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        if ($isunknown(trace_mem[0]) || $isunknown(trace_mem[n_req*4-1])) begin
            tb_errors++;
            $display("trace file is missing or shorter than %0d requests", n_req);
        end else begin
            for (int i = 0; i < n_req; i++) run_request(i);
        end
        repeat (4) @(posedge clk);
        if (resp_count != n_req) begin
            tb_errors++;
            $display("only %0d of %0d requests completed", resp_count, n_req);
        end
        $display("checker errors %0d, stimulus errors %0d", error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: mmio_bridge.f
hdl/mmio_pkg.sv
hdl/mmio_if.sv
hdl/mmio_addr_decode.sv
hdl/mmio_target_route.sv
hdl/mmio_return_stage.sv
hdl/mmio_bridge.sv
testbench/mmio_checker.sv
testbench/tb_mmio_bridge.sv

// File: testbench/mmio_trace.txt
// columns: cpu address, op (0 fetch, 1 write, 2 read, 3 idle), write data, target read data
// one request per line, all values in hex
00000010 0 00000000 a0010001
00000400 2 00000000 a0020002
00000401 2 00000000 5a5a0003
00000420 2 00000000 5a5a0004
00000421 2 00000000 c0de0005
00000421 1 12345678 00000006
00000700 2 00000000 c0de0007
00000701 1 cafe0008 00000008
000007ff 1 cafe0009 00000009
00000800 2 00000000 dead000a
00000410 1 1111000b dead000b
00000710 2 00000000 dead000c
00000500 0 00000000 dead000d
00000200 1 2222000e a001000e
00010500 2 00000000 dead000f
ffffffff 1 33330010 dead0010
00000003 0 00000000 a0010011
00000600 2 00000000 c0de0012
